// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = fdc_tb
FILELIST = sources.f

BUILD = obj_dir
BIN   = $(BUILD)/V$(TOP)
LOG   = sim.log
PASS  = TEST OK

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS)$$" $(LOG) && echo "simulation passed" || (echo "simulation failed"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// File: rtl/fdc_controller.sv
`timescale 1ns/1ps

module fdc_controller #(
	parameter int SECTORS_PER_TRACK = 10
) (
	input  logic                            clk,
	input  logic                            cock,
	input  logic                            clken,
	// host bus
	input  logic                            rd,
	input  logic                            wr,
	input  logic [2:0]                      addr,
	input  logic [7:0]                      wdata,
	output logic [7:0]                      rdata,
	// register views
	output logic [7:0]                      track,
	output logic [7:0]                      sector,
	output logic [7:0]                      status,
	output logic                            irq,
	output logic                            drq,
	output logic                            lost_data,
	// workhorse link
	output logic [7:0]                      cpu_request,
	input  logic [7:0]                      cpu_status,
	// sector buffer
	output logic [fdc_link_pkg::BUF_AW-1:0] buf_addr,
	input  logic [7:0]                      buf_data,
	// watchdog
	output logic                            dog_kick,
	input  logic                            bark
);

	localparam int CW = fdc_link_pkg::BUF_AW + 1; // count must hold 512

	typedef enum logic {ST_READY, ST_WAIT} state_t;

	state_t      state;
	logic [7:0]  track_reg;
	logic [7:0]  sector_reg;
	logic [7:0]  head_pos;    // where the head really is
	logic        step_out;    // remembered step direction
	logic        side;
	logic        multi;
	logic        addr_cmd;    // current read is READ ADDRESS
	logic [CW-1:0] xfer_cnt;
	logic        cmd_mode;    // bit 7 of last command, picks status view
	logic        s_busy, s_drq, s_lost, s_seekerr, s_headload;
	logic        track0;
	logic        step_dir;
	logic [7:0]  next_head;
	logic        byte_rd;
	logic        read_ok;

	// a STEP without direction reuses the last one
	assign step_dir  = wdata[fdc_regs_pkg::BIT_STEP_DIR_GIVEN] ?
		wdata[fdc_regs_pkg::BIT_STEP_OUT] : step_out;
	assign next_head = step_dir ? head_pos - 8'd1 : head_pos + 8'd1;
	assign track0    = (head_pos == 8'd0);

	assign byte_rd = clken && rd && (addr == fdc_regs_pkg::A_DATA) &&
		(xfer_cnt != '0) && !bark;
	assign read_ok = clken && (state == ST_WAIT) &&
		cpu_status[fdc_link_pkg::WS_DONE] && cpu_status[fdc_link_pkg::WS_OK];
	assign dog_kick = byte_rd | read_ok;

	always_comb begin
		status = '0;
		status[fdc_regs_pkg::SB_BUSY]     = s_busy;
		status[fdc_regs_pkg::SB_NOTREADY] = 1'b0; // emulated drive is always there
		status[fdc_regs_pkg::SB_READONLY] = 1'b0;
		status[fdc_regs_pkg::SB_CRCERR]   = 1'b0;
		status[fdc_regs_pkg::SB_SEEKERR]  = s_seekerr;
		if (cmd_mode) begin
			status[fdc_regs_pkg::SB_DRQ]      = s_drq;
			status[fdc_regs_pkg::SB_LOSTDATA] = s_lost;
		end else begin
			status[fdc_regs_pkg::SB_INDEX]    = 1'b0; // no index pulses
			status[fdc_regs_pkg::SB_TRACK0]   = track0;
			status[fdc_regs_pkg::SB_HEADLOAD] = s_headload;
		end
	end

	always_ff @(posedge clk or posedge cock) begin
		if (cock) begin
			state       <= ST_READY;
			rdata       <= '0;
			track_reg   <= '0;
			sector_reg  <= '0;
			head_pos    <= 8'hFF; // unknown position, not on track 0
			step_out    <= 1'b0;
			side        <= 1'b0;
			multi       <= 1'b0;
			addr_cmd    <= 1'b0;
			xfer_cnt    <= '0;
			buf_addr    <= '0;
			cpu_request <= fdc_link_pkg::REQ_IDLE;
			cmd_mode    <= 1'b0;
			s_busy      <= 1'b0;
			s_drq       <= 1'b0;
			s_lost      <= 1'b0;
			s_seekerr   <= 1'b0;
			s_headload  <= 1'b0;
			irq         <= 1'b0;
		end else if (clken) begin
			if (rd) begin
				case (addr)
					fdc_regs_pkg::A_COMMAND_STATUS: rdata <= status;
					fdc_regs_pkg::A_TRACK:          rdata <= track_reg;
					fdc_regs_pkg::A_SECTOR:         rdata <= sector_reg;
					fdc_regs_pkg::A_DATA: if (byte_rd) rdata <= buf_data;
					default: ;
				endcase
			end

			case (state)
				ST_READY: begin
					if (s_drq && bark) begin
						// host stopped reading, abandon the transfer
						xfer_cnt <= '0;
						s_lost   <= 1'b1;
						s_drq    <= 1'b0;
						s_busy   <= 1'b0;
						multi    <= 1'b0;
					end else if (byte_rd) begin
						buf_addr <= buf_addr + 1'b1;
						xfer_cnt <= xfer_cnt - 1'b1;
						if (xfer_cnt == CW'(1)) begin
							if (multi && sector_reg < 8'(SECTORS_PER_TRACK)) begin
								sector_reg  <= sector_reg + 8'd1;
								cpu_request <= fdc_link_pkg::REQ_READ | {7'd0, side};
								s_drq       <= 1'b0;
								state       <= ST_WAIT;
							end else begin
								s_busy <= 1'b0;
								s_drq  <= 1'b0;
								multi  <= 1'b0;
								irq    <= 1'b1;
							end
						end
					end else if (wr && !s_busy) begin
						case (addr)
							fdc_regs_pkg::A_TRACK:  track_reg  <= wdata;
							fdc_regs_pkg::A_SECTOR: sector_reg <= wdata;
							fdc_regs_pkg::A_COMMAND_STATUS: begin
								cmd_mode  <= wdata[7];
								s_seekerr <= 1'b0;
								case (wdata[7:4])
									fdc_regs_pkg::CMD_RESTORE: begin
										head_pos   <= 8'd0;
										track_reg  <= 8'd0;
										s_headload <= wdata[fdc_regs_pkg::BIT_HEAD_LOAD];
										irq        <= 1'b1;
									end
									fdc_regs_pkg::CMD_SEEK: begin
										head_pos   <= track_reg;
										s_headload <= wdata[fdc_regs_pkg::BIT_HEAD_LOAD];
										irq        <= 1'b1;
									end
									fdc_regs_pkg::CMD_READ,
									fdc_regs_pkg::CMD_READ | 4'h1: begin
										cpu_request <= fdc_link_pkg::REQ_READ |
											{7'd0, wdata[fdc_regs_pkg::BIT_HEAD_LOAD]};
										side     <= wdata[fdc_regs_pkg::BIT_HEAD_LOAD];
										multi    <= wdata[fdc_regs_pkg::BIT_UPDATE];
										addr_cmd <= 1'b0;
										s_busy   <= 1'b1;
										s_drq    <= 1'b0;
										s_lost   <= 1'b0;
										irq      <= 1'b0;
										state    <= ST_WAIT;
									end
									fdc_regs_pkg::CMD_READ_ADDR: begin
										// side is whatever the last read selected
										cpu_request <= fdc_link_pkg::REQ_READ_ADDR | {7'd0, side};
										multi    <= 1'b0;
										addr_cmd <= 1'b1;
										s_busy   <= 1'b1;
										s_drq    <= 1'b0;
										s_lost   <= 1'b0;
										irq      <= 1'b0;
										state    <= ST_WAIT;
									end
									default: begin
										if (!wdata[7]) begin // the six STEP forms
											if (wdata[fdc_regs_pkg::BIT_STEP_DIR_GIVEN])
												step_out <= wdata[fdc_regs_pkg::BIT_STEP_OUT];
											head_pos <= next_head;
											if (wdata[fdc_regs_pkg::BIT_UPDATE])
												track_reg <= next_head;
											s_headload <= wdata[fdc_regs_pkg::BIT_HEAD_LOAD];
											irq        <= 1'b1;
										end
										// write sector and track commands fall through unserved
									end
								endcase
							end
							default: ;
						endcase
					end
				end
				ST_WAIT: begin
					if (cpu_status[fdc_link_pkg::WS_DONE]) begin
						cpu_request <= fdc_link_pkg::REQ_IDLE;
						state       <= ST_READY;
						if (cpu_status[fdc_link_pkg::WS_OK]) begin
							s_drq    <= 1'b1;
							irq      <= 1'b0;
							buf_addr <= '0;
							xfer_cnt <= addr_cmd ? CW'(fdc_link_pkg::ADDR_BYTES) :
								CW'(fdc_link_pkg::SECTOR_BYTES);
						end else begin
							s_seekerr <= 1'b1; // sector not found
							s_busy    <= 1'b0;
							multi     <= 1'b0;
							irq       <= 1'b1;
						end
					end
				end
				default: state <= ST_READY;
			endcase
		end
	end

	assign track     = head_pos;
	assign sector    = sector_reg;
	assign drq       = s_drq;
	assign lost_data = s_lost;

	a_drq_busy: assert property (@(posedge clk) disable iff (cock) s_drq |-> s_busy)
		else $error("drq set without busy");

	a_request_busy: assert property (@(posedge clk) disable iff (cock)
		(cpu_request != fdc_link_pkg::REQ_IDLE) |-> s_busy)
		else $error("workhorse request pending while idle");

endmodule

// File: rtl/fdc_link_pkg.sv
package fdc_link_pkg;

	// request codes toward the workhorse, side goes in bit 0
	localparam logic [7:0] REQ_READ      = 8'h10;
	localparam logic [7:0] REQ_READ_ADDR = 8'h30;
	localparam logic [7:0] REQ_IDLE      = 8'h80; // nothing pending

	// workhorse status byte
	localparam int WS_DONE = 0;
	localparam int WS_OK   = 1; // only meaningful with done

	// sector buffer geometry
	localparam int SECTOR_BYTES = 512;
	localparam int ADDR_BYTES   = 6; // track, side, sector, size, crc x2
	localparam int BUF_AW       = 9;

endpackage

// File: rtl/fdc_regs_pkg.sv
package fdc_regs_pkg;

	// host register map, 3-bit address
	localparam logic [2:0] A_COMMAND_STATUS = 3'd0; // write command, read status
	localparam logic [2:0] A_TRACK          = 3'd1;
	localparam logic [2:0] A_SECTOR         = 3'd2;
	localparam logic [2:0] A_DATA           = 3'd3;

	// command groups, upper nibble of the command byte
	localparam logic [3:0] CMD_RESTORE   = 4'h0;
	localparam logic [3:0] CMD_SEEK      = 4'h1;
	localparam logic [3:0] CMD_READ      = 4'h8; // 4'h9 is the multi-sector form
	localparam logic [3:0] CMD_READ_ADDR = 4'hC;

	// command byte fields
	localparam int BIT_STEP_DIR_GIVEN = 6;
	localparam int BIT_STEP_OUT       = 5; // 1 steps toward track 0
	localparam int BIT_UPDATE         = 4; // also multi-sector for reads
	localparam int BIT_HEAD_LOAD      = 3; // also side select for reads

	// status bits shared by all commands
	localparam int SB_BUSY     = 0;
	localparam int SB_CRCERR   = 3;
	localparam int SB_SEEKERR  = 4;
	localparam int SB_READONLY = 6;
	localparam int SB_NOTREADY = 7;

	// type I view
	localparam int SB_INDEX    = 1;
	localparam int SB_TRACK0   = 2;
	localparam int SB_HEADLOAD = 5;

	// read command view
	localparam int SB_DRQ      = 1;
	localparam int SB_LOSTDATA = 2;

endpackage

// File: rtl/fdc_sector_buffer.sv
`timescale 1ns/1ps

module fdc_sector_buffer (
	input  logic                            clk,
	// workhorse fill port
	input  logic                            fill_wr,
	input  logic [fdc_link_pkg::BUF_AW-1:0] fill_addr,
	input  logic [7:0]                      fill_data,
	// controller read port
	input  logic [fdc_link_pkg::BUF_AW-1:0] rd_addr,
	output logic [7:0]                      rd_data
);

	logic [7:0] mem [fdc_link_pkg::SECTOR_BYTES];

	always_ff @(posedge clk) begin
		if (fill_wr)
			mem[fill_addr] <= fill_data;
	end

	// registered read, data follows the address by one clock
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

	a_fill_in_range: assert property (@(posedge clk)
		fill_wr |-> (int'(fill_addr) < fdc_link_pkg::SECTOR_BYTES))
		else $error("fill address outside sector buffer");

endmodule

// File: rtl/fdc_top.sv
`timescale 1ns/1ps

module fdc_top #(
	parameter int SECTORS_PER_TRACK = 10,
	parameter int WATCHDOG_TIME     = 255
) (
	input  logic                            clk,
	input  logic                            cock,
	input  logic                            clken,
	// host bus
	input  logic                            rd,
	input  logic                            wr,
	input  logic [2:0]                      addr,
	input  logic [7:0]                      wdata,
	output logic [7:0]                      rdata,
	// register views
	output logic [7:0]                      track,
	output logic [7:0]                      sector,
	output logic [7:0]                      status,
	output logic                            irq,
	output logic                            drq,
	output logic                            lost_data,
	// workhorse side
	output logic [7:0]                      cpu_request,
	input  logic [7:0]                      cpu_status,
	input  logic                            fill_wr,
	input  logic [fdc_link_pkg::BUF_AW-1:0] fill_addr,
	input  logic [7:0]                      fill_data
);

	logic [fdc_link_pkg::BUF_AW-1:0] buf_addr;
	logic [7:0]                      buf_data;
	logic                            dog_kick;
	logic                            bark;

	fdc_controller #(
		.SECTORS_PER_TRACK(SECTORS_PER_TRACK)
	) u_ctrl (
		.clk(clk), .cock(cock), .clken(clken),
		.rd(rd), .wr(wr), .addr(addr), .wdata(wdata), .rdata(rdata),
		.track(track), .sector(sector), .status(status),
		.irq(irq), .drq(drq), .lost_data(lost_data),
		.cpu_request(cpu_request), .cpu_status(cpu_status),
		.buf_addr(buf_addr), .buf_data(buf_data),
		.dog_kick(dog_kick), .bark(bark)
	);

	fdc_sector_buffer u_buf (
		.clk(clk),
		.fill_wr(fill_wr), .fill_addr(fill_addr), .fill_data(fill_data),
		.rd_addr(buf_addr), .rd_data(buf_data)
	);

	// ends a transfer the host has abandoned
	fdc_watchdog #(
		.WATCHDOG_TIME(WATCHDOG_TIME)
	) u_dog (
		.clk(clk), .cock(cock), .clken(clken),
		.kick(dog_kick), .bark(bark)
	);

endmodule

// File: rtl/fdc_watchdog.sv
`timescale 1ns/1ps

module fdc_watchdog #(
	parameter int WATCHDOG_TIME = 255
) (
	input  logic clk,
	input  logic cock,
	input  logic clken,
	input  logic kick,
	output logic bark
);

	logic [7:0] count;

	always_ff @(posedge clk or posedge cock) begin
		if (cock)
			count <= 8'(WATCHDOG_TIME);
		else if (kick)
			count <= 8'(WATCHDOG_TIME); // any activity rearms
		else if (clken && count != 8'd0)
			count <= count - 8'd1;
	end

	assign bark = (count == 8'd0);

	// reload value has to fit the 8-bit counter
	a_reload_fits: assert property (@(posedge clk) disable iff (cock)
		kick |=> (int'(count) == WATCHDOG_TIME))
		else $error("watchdog reload value does not fit the counter");

endmodule

// File: sources.f
rtl/fdc_regs_pkg.sv
rtl/fdc_link_pkg.sv
rtl/fdc_watchdog.sv
rtl/fdc_sector_buffer.sv
rtl/fdc_controller.sv
rtl/fdc_top.sv
verif/fdc_tb_clock.sv
verif/fdc_tb.sv

// File: verif/fdc_stim.txt
// word = op a b c; 01 write reg a=b, 02 read reg a expect b, 03 queue fill kind a base b ok c
// 04 expect request b, 05 irq=a drq=b lost=c, 06 wait drq, 07 read {a,b} bytes, clken gap at c
// 08 address byte a=b, 09 wait irq, 0a stall after a bytes, 0b head position a, 00 end
// fill kinds: 0 incrementing from base, 1 random, 2 address bytes

// track and sector read back
01012300 01020700 02012300 02020700

// restore with head load
05000000 01000800 05010000 02010000 02002400 0b000000

// step in with update, then step with no direction
01005000 02010100 0b010000 02000000
01003800 02010200 0b020000 02002000

// step out without update, then repeat direction with update
01006000 0b010000 02010200
01003000 0b000000 02010000 02000400

// seek to 5
01010500 01001800 0b050000 02010500 02002000

// single sector read, side 1
01020300 03000001 01008800 04001100
01024400 02020300
06000000 05000100 02000300
07020064 05010000 02000000

// multi-sector read from sector 9
01020900 03010001 0300a001 01009000 04001000
06000000 07020000
04001000 02020a00
06000000 07020000 05010000 02020a00 02000000

// read address
08000500 08010000 08020a00 08030200 08045a00 0805c300
03020001 0100c000 04003000 06000000 07000600 05010000

// workhorse reports failure
03000000 01008000 04001000 09000000 05010000 02001000

// host stops after three bytes
03010001 01008000 04001000 06000000
0a030000 05000001 02000400 02030400

00000000

// File: verif/fdc_tb.sv
`timescale 1ns/1ps

module fdc_tb;

	logic                            clk;
	logic                            cock;
	logic                            clken;
	logic                            rd;
	logic                            wr;
	logic [2:0]                      addr;
	logic [7:0]                      wdata;
	logic [7:0]                      rdata;
	logic [7:0]                      track;
	logic [7:0]                      sector;
	logic [7:0]                      status;
	logic                            irq;
	logic                            drq;
	logic                            lost_data;
	logic [7:0]                      cpu_request;
	logic [7:0]                      cpu_status;
	logic                            fill_wr;
	logic [fdc_link_pkg::BUF_AW-1:0] fill_addr;
	logic [7:0]                      fill_data;

	logic [31:0] stim [0:127];   // op, a, b, c per record
	logic [23:0] fills [$];      // kind, base, ok for each workhorse answer
	logic [7:0]  addr_bytes [6];
	logic [7:0]  exp_buf [fdc_link_pkg::SECTOR_BYTES]; // bytes the workhorse put in
	integer      seed;
	string       tname;

	fdc_tb_clock #(.PERIOD(20)) u_clk (.clk(clk));

	fdc_top #(
		.SECTORS_PER_TRACK(10),
		.WATCHDOG_TIME(40)
	) uut (
		.clk(clk), .cock(cock), .clken(clken),
		.rd(rd), .wr(wr), .addr(addr), .wdata(wdata), .rdata(rdata),
		.track(track), .sector(sector), .status(status),
		.irq(irq), .drq(drq), .lost_data(lost_data),
		.cpu_request(cpu_request), .cpu_status(cpu_status),
		.fill_wr(fill_wr), .fill_addr(fill_addr), .fill_data(fill_data)
	);

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
			stop_run($sformatf("FAILED %s expected %02h actual %02h", what, exp, act));
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		if (act !== exp)
			stop_run($sformatf("FAILED %s expected %b actual %b", what, exp, act));
	endtask

	task automatic check_request(input string what, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
			stop_run($sformatf("FAILED %s expected %02h actual %02h", what, exp, act));
	endtask

	task automatic write_reg(input logic [2:0] a, input logic [7:0] d);
		@(posedge clk);
		#2;
		wr    = 1'b1;
		addr  = a;
		wdata = d;
		@(posedge clk);
		#2;
		wr = 1'b0;
	endtask

	// value shows on rdata at the edge that samples the strobe
	task automatic read_reg(input logic [2:0] a, output logic [7:0] d);
		@(posedge clk);
		#2;
		rd   = 1'b1;
		addr = a;
		@(posedge clk);
		#2;
		rd = 1'b0;
		d  = rdata;
	endtask

	function automatic logic level_of(input int sel);
		case (sel)
			0: return drq === 1'b1;
			1: return irq === 1'b1;
			default: return cpu_request !== fdc_link_pkg::REQ_IDLE;
		endcase
	endfunction

	task automatic wait_high(input int sel, input int limit, input string what);
		int n;
		n = 0;
		while (!level_of(sel)) begin
			if (n >= limit)
				stop_run(what);
			@(posedge clk);
			#1;
			n++;
		end
	endtask

	task automatic drain_bytes(input int count, input int gap);
		logic [7:0] v;
		for (int i = 0; i < count; i++) begin
			if (gap != 0 && i == gap) begin
				@(posedge clk);
				#2;
				clken = 1'b0; // controller frozen for a while
				repeat (20) @(posedge clk);
				#2;
				rd   = 1'b1; // a data read the frozen controller must not take
				addr = fdc_regs_pkg::A_DATA;
				@(posedge clk);
				#2;
				rd = 1'b0;
				repeat (40) @(posedge clk); // longer than the watchdog time
				#2;
				clken = 1'b1;
				check_flag($sformatf("%s drq after pause", tname), 1'b1, drq);
			end
			read_reg(fdc_regs_pkg::A_DATA, v);
			check_byte($sformatf("%s byte %0d", tname, i), exp_buf[i], v);
		end
	endtask

	task automatic stall_host(input int count);
		logic [7:0] v;
		int polls;
		drain_bytes(count, 0);
		polls = 0;
		v     = 8'h00;
		while (!v[fdc_regs_pkg::SB_LOSTDATA]) begin
			if (polls > 100)
				stop_run("lost data never set after the host stopped reading");
			read_reg(fdc_regs_pkg::A_COMMAND_STATUS, v);
			polls++;
		end
	endtask

	// workhorse side of the link, one request per call
	task automatic serve_request();
		logic [23:0] rec;
		logic [31:0] r;
		int idle;
		int n;
		idle = 0;
		while (cpu_request === fdc_link_pkg::REQ_IDLE) begin
			@(posedge clk);
			#2;
			idle++;
			if (idle > 20000)
				stop_run("workhorse saw no request for too long");
		end
		if (fills.size() == 0)
			stop_run("controller made a request with no fill record queued");
		rec = fills.pop_front();
		n   = (rec[23:16] == 8'd2) ? fdc_link_pkg::ADDR_BYTES : fdc_link_pkg::SECTOR_BYTES;
		for (int i = 0; i < n; i++) begin
			case (rec[23:16])
				8'd0: exp_buf[i] = rec[15:8] + 8'(i) + ((i >= 256) ? 8'h40 : 8'h00);
				8'd1: begin
					r          = $random(seed);
					exp_buf[i] = r[7:0];
				end
				default: exp_buf[i] = addr_bytes[i];
			endcase
			fill_wr   = 1'b1;
			fill_addr = i[fdc_link_pkg::BUF_AW-1:0];
			fill_data = exp_buf[i];
			@(posedge clk);
			#2;
		end
		fill_wr = 1'b0;
		cpu_status[fdc_link_pkg::WS_DONE] = 1'b1;
		cpu_status[fdc_link_pkg::WS_OK]   = rec[0];
		idle = 0;
		while (cpu_request !== fdc_link_pkg::REQ_IDLE) begin
			@(posedge clk);
			#2;
			idle++;
			if (idle > 100)
				stop_run("controller kept its request after done");
		end
		cpu_status = 8'h00;
	endtask

	initial begin : workhorse
		cpu_status = 8'h00;
		fill_wr    = 1'b0;
		fill_addr  = '0;
		fill_data  = 8'h00;
		repeat (4) @(posedge clk);
		#2;
		forever serve_request();
	end

	initial begin : main
		logic [7:0] v;
		logic [7:0] op;
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] c;
		int idx;
		seed  = 37;
		cock  = 1'b1;
		clken = 1'b1;
		rd    = 1'b0;
		wr    = 1'b0;
		addr  = 3'd0;
		wdata = 8'h00;
		$readmemh("verif/fdc_stim.txt", stim);
		repeat (2) @(posedge clk);
		#2;
		cock = 1'b0;
		idx  = 0;
		while (idx < 128 && stim[idx][31:24] !== 8'h00) begin
			{op, a, b, c} = stim[idx];
			tname = $sformatf("rec %0d op %02h", idx, op);
			case (op)
				8'h01: write_reg(a[2:0], b);
				8'h02: begin
					read_reg(a[2:0], v);
					check_byte(tname, b, v);
					// register views must agree with the bus
					if (a[2:0] == fdc_regs_pkg::A_SECTOR)
						check_byte($sformatf("%s sector port", tname), b, sector);
					else if (a[2:0] == fdc_regs_pkg::A_COMMAND_STATUS)
						check_byte($sformatf("%s status port", tname), b, status);
				end
				8'h03: fills.push_back({a, b, c});
				8'h04: begin
					wait_high(2, 20, "no workhorse request after the read command");
					check_request(tname, b, cpu_request);
				end
				8'h05: begin
					check_flag($sformatf("%s irq", tname), a[0], irq);
					check_flag($sformatf("%s drq", tname), b[0], drq);
					check_flag($sformatf("%s lost_data", tname), c[0], lost_data);
				end
				8'h06: wait_high(0, 2000, "drq never rose after the sector was filled");
				8'h07: drain_bytes(int'({a, b}), int'(c));
				8'h08: addr_bytes[a] = b;
				8'h09: wait_high(1, 2000, "irq never rose after the read command");
				8'h0a: stall_host(int'(a));
				8'h0b: check_byte($sformatf("%s head", tname), a, track);
				default: stop_run($sformatf("unknown stim op %02h at record %0d", op, idx));
			endcase
			idx++;
		end
		$display("TEST OK");
		$finish;
	end

endmodule

// File: verif/fdc_tb_clock.sv
`timescale 1ns/1ps

module fdc_tb_clock #(
	parameter int PERIOD = 20
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

endmodule
